/* src/spiBusPkg.sv */
/*
 * Host bus types shared by the SPI block and its bus-side logic.
 * Writes and read requests are single-cycle strobes with no back-pressure.
 */
package spiBusPkg;

	// ------------------------------------------------------------------------
	// Widths
	// ------------------------------------------------------------------------
	localparam int BusAdrsBitDef = 16;	// Default word address width

	typedef logic [BusAdrsBitDef-1:0]	busAdrs_t;	// Word address
	typedef logic [31:0]				busData_t;	// Bus data word

	// ------------------------------------------------------------------------
	// Transfer records
	// ------------------------------------------------------------------------
	// One host write, valid while strobe is high
	typedef struct packed {
		busAdrs_t	adrs;	// Target register
		busData_t	data;	// Write data
		logic		strobe;	// Single-cycle write enable
	} busWr_t;

	// Read request, answered one cycle later
	typedef struct packed {
		busAdrs_t	adrs;	// Register to read
		logic		strobe;	// Single-cycle read enable
	} busRdReq_t;

	// Read response
	typedef struct packed {
		busData_t	data;	// Zero when address is unmapped
		logic		valid;	// One cycle after the request
	} busRdRsp_t;

endpackage

/* src/spiCfgPkg.sv */
/*
 * SPI channel types: divider and byte widths, register offsets,
 * and the config and status records passed between CSR, engines and collector.
 */
package spiCfgPkg;

	typedef logic [15:0]	spiDiv_t;	// Half period = div + 1 clocks
	typedef logic [7:0]		spiByte_t;	// Shift width

	// Per-channel register offsets, four words per channel
	typedef enum logic [1:0] {
		RegCtrl	= 2'd0,	// Enable, chip select, busy
		RegDiv	= 2'd1,	// Clock divider
		RegTx	= 2'd2,	// Write starts a transfer
		RegRx	= 2'd3	// Last received byte
	} regOfs_t;

	// RegCtrl bit positions
	localparam int CtrlEnBit	= 0;
	localparam int CtrlCsBit	= 1;
	localparam int CtrlBusyBit	= 2;	// Read only

	// CSR to channel
	typedef struct packed {
		logic		en;			// Channel enable
		logic		csAssert;	// Chip select level while idle
		spiDiv_t	div;
		spiByte_t	txData;
		logic		start;		// One-cycle transfer request
	} chanCfg_t;

	// Channel to collector
	typedef struct packed {
		spiByte_t	rxData;	// Valid from the done cycle on
		logic		busy;
		logic		done;	// One-cycle end of transfer
	} chanStat_t;

	// Channel FSM
	typedef enum logic [1:0] {Idle, Lead, Shift, Trail} chanState_t;

endpackage

/* src/spiCsr.sv */
`timescale 1ns/1ps
/*
 * Write side of the register map. Decodes host writes into per-channel
 * control, divider and transmit registers and pulses start on a RegTx write.
 */
module spiCsr #(
	parameter int						NumChan		= 4,
	parameter int						BusAdrsBit	= spiBusPkg::BusAdrsBitDef,
	parameter logic [BusAdrsBit-1:0]	BaseAdrs	= 'h0300
)(
	input	logic									sysClk,
	input	logic									arstN,
	input	spiBusPkg::busWr_t						wr,		// Host write strobe
	output	spiCfgPkg::chanCfg_t [NumChan-1:0]		cfg		// One entry per channel
);

	import spiCfgPkg::*;

	// ------------------------------------------------------------------------
	// Address decode
	// ------------------------------------------------------------------------
	localparam int						ChanBit	= (NumChan > 1) ? $clog2(NumChan) : 1;
	localparam logic [BusAdrsBit-1:0]	MapSize	= BusAdrsBit'(NumChan * 4);

	logic [BusAdrsBit-1:0]	adrs;		// Write address at decode width
	logic [BusAdrsBit-1:0]	ofs;		// Offset from block base
	logic					inMap;
	logic [ChanBit-1:0]		chanSel;
	regOfs_t				regSel;
	logic [NumChan-1:0]		startVec;	// Start bits gathered for checking

	assign adrs		= BusAdrsBit'(wr.adrs);
	assign ofs		= adrs - BaseAdrs;
	assign inMap	= (adrs >= BaseAdrs) && (ofs < MapSize);	// Below base wraps high
	assign chanSel	= ofs[ChanBit+1:2];		// Four words per channel
	assign regSel	= regOfs_t'(ofs[1:0]);

	// ------------------------------------------------------------------------
	// Register file
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			cfg <= '0;
		end
		else
		begin
			// Start lasts one cycle only
			for (int k = 0; k < NumChan; k++)
			begin
				cfg[k].start <= 1'b0;
			end

			if (wr.strobe && inMap)
			begin
				case (regSel)
					RegCtrl:
					begin
						cfg[chanSel].en			<= wr.data[CtrlEnBit];
						cfg[chanSel].csAssert	<= wr.data[CtrlCsBit];	// Busy bit ignored
					end
					RegDiv:
					begin
						cfg[chanSel].div <= spiDiv_t'(wr.data);
					end
					RegTx:
					begin
						cfg[chanSel].txData	<= spiByte_t'(wr.data);
						cfg[chanSel].start	<= 1'b1;	// Channel decides whether to take it
					end
					default:
					begin
						// RegRx is read only
					end
				endcase
			end
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	always_comb
	begin
		for (int k = 0; k < NumChan; k++)
		begin
			startVec[k] = cfg[k].start;
		end
	end

	// One write per cycle, so never two channels started together
	startOneHot: assert property (
		@(posedge sysClk) disable iff (!arstN)
		$onehot0(startVec)
	);

endmodule

/* src/spiChannel.sv */
`timescale 1ns/1ps
/*
 * One SPI mode-0 byte engine, MSB first. Takes a start pulse when idle and
 * enabled, runs 17 half periods with csN low, then pulses done.
 */
module spiChannel (
	input	logic					sysClk,
	input	logic					arstN,
	input	spiCfgPkg::chanCfg_t	cfg,	// From CSR
	input	logic					miso,
	output	logic					sck,
	output	logic					mosi,
	output	logic					csN,
	output	spiCfgPkg::chanStat_t	stat	// To collector
);

	import spiCfgPkg::*;

	chanState_t		state;
	spiDiv_t		divLatch;	// Divider frozen for the whole byte
	spiDiv_t		halfCnt;	// Clocks left in this half period
	logic [2:0]		bitCnt;		// Falling edges seen
	spiByte_t		txShift;
	spiByte_t		rxShift;
	spiByte_t		rxReg;		// Last complete byte
	logic			doneReg;
	logic			halfEnd;

	assign halfEnd	= (halfCnt == '0);
	assign mosi		= txShift[7];	// First bit already out in Lead
	assign stat		= '{rxData: rxReg, busy: (state != Idle), done: doneReg};

	// ------------------------------------------------------------------------
	// Transfer FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			state		<= Idle;
			sck			<= 1'b0;
			csN			<= 1'b1;
			divLatch	<= '0;
			halfCnt		<= '0;
			bitCnt		<= '0;
			txShift		<= '0;
			rxShift		<= '0;
			rxReg		<= '0;
			doneReg		<= 1'b0;
		end
		else
		begin
			doneReg <= 1'b0;

			case (state)
				Idle:
				begin
					csN <= ~cfg.csAssert;	// Software-held chip select
					if (cfg.start && cfg.en)
					begin
						state		<= Lead;
						csN			<= 1'b0;
						divLatch	<= cfg.div;
						halfCnt		<= cfg.div;
						bitCnt		<= '0;
						txShift		<= cfg.txData;
					end
				end
				Lead:
				begin
					if (halfEnd)
					begin
						state	<= Shift;
						sck		<= 1'b1;	// First rising edge
						rxShift	<= {rxShift[6:0], miso};
					end
				end
				Shift:
				begin
					if (halfEnd)
					begin
						sck <= ~sck;
						if (!sck)
						begin
							rxShift <= {rxShift[6:0], miso};	// Sample on rise
						end
						else if (bitCnt == 3'd7)
						begin
							state <= Trail;	// Eighth fall, hold low one half
						end
						else
						begin
							txShift	<= txShift << 1;	// Next bit on fall
							bitCnt	<= bitCnt + 3'd1;
						end
					end
				end
				Trail:
				begin
					if (halfEnd)
					begin
						state	<= Idle;
						csN		<= ~cfg.csAssert;
						txShift	<= '0;		// mosi back low
						rxReg	<= rxShift;
						doneReg	<= 1'b1;
					end
				end
				default:
				begin
					state <= Idle;
				end
			endcase

			// Half-period timer, reloaded from the latched divider
			if (state != Idle)
			begin
				halfCnt <= halfEnd ? divLatch : halfCnt - 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	idleSckLow: assert property (
		@(posedge sysClk) disable iff (!arstN)
		(state == Idle) |-> !sck
	);

	// Idle chip select tracks csAssert with one register stage
	idleCsLevel: assert property (
		@(posedge sysClk) disable iff (!arstN)
		(state == Idle) |-> (csN == !$past(cfg.csAssert))
	);

endmodule

/* src/spiReadCollect.sv */
`timescale 1ns/1ps
/*
 * Read side of the register map and interrupt gathering. Answers each
 * read one cycle later and turns channel done strobes into irq pulses.
 */
module spiReadCollect #(
	parameter int						NumChan		= 4,
	parameter int						BusAdrsBit	= spiBusPkg::BusAdrsBitDef,
	parameter logic [BusAdrsBit-1:0]	BaseAdrs	= 'h0300
)(
	input	logic									sysClk,
	input	logic									arstN,
	input	spiBusPkg::busRdReq_t					rdReq,
	input	spiCfgPkg::chanCfg_t [NumChan-1:0]		cfg,	// Control and divider read-back
	input	spiCfgPkg::chanStat_t [NumChan-1:0]		stat,
	output	spiBusPkg::busRdRsp_t					rdRsp,
	output	logic [NumChan-1:0]						irq		// One bit per channel
);

	import spiBusPkg::*;
	import spiCfgPkg::*;

	localparam int						ChanBit	= (NumChan > 1) ? $clog2(NumChan) : 1;
	localparam logic [BusAdrsBit-1:0]	MapSize	= BusAdrsBit'(NumChan * 4);

	logic [BusAdrsBit-1:0]	adrs;
	logic [BusAdrsBit-1:0]	ofs;
	logic					inMap;
	logic [ChanBit-1:0]		chanSel;
	regOfs_t				regSel;
	busData_t				rdData;		// Selected word before the register
	logic [NumChan-1:0]		doneVec;

	assign adrs		= BusAdrsBit'(rdReq.adrs);
	assign ofs		= adrs - BaseAdrs;
	assign inMap	= (adrs >= BaseAdrs) && (ofs < MapSize);
	assign chanSel	= ofs[ChanBit+1:2];
	assign regSel	= regOfs_t'(ofs[1:0]);

	// ------------------------------------------------------------------------
	// Read mux, zero outside the map
	// ------------------------------------------------------------------------
	always_comb
	begin
		rdData = '0;
		if (inMap)
		begin
			case (regSel)
				RegCtrl:
				begin
					rdData[CtrlEnBit]	= cfg[chanSel].en;
					rdData[CtrlCsBit]	= cfg[chanSel].csAssert;
					rdData[CtrlBusyBit]	= stat[chanSel].busy;	// Live
				end
				RegDiv:		rdData = busData_t'(cfg[chanSel].div);
				RegTx:		rdData = busData_t'(cfg[chanSel].txData);
				default:	rdData = busData_t'(stat[chanSel].rxData);
			endcase
		end
	end

	always_comb
	begin
		for (int k = 0; k < NumChan; k++)
		begin
			doneVec[k] = stat[k].done;
		end
	end

	always_ff @(posedge sysClk or negedge arstN)
	begin
		if (!arstN)
		begin
			rdRsp	<= '0;
			irq		<= '0;
		end
		else
		begin
			rdRsp.valid	<= rdReq.strobe;
			rdRsp.data	<= rdReq.strobe ? rdData : '0;
			irq			<= doneVec;	// Done delayed one cycle
		end
	end

	// Back-to-back responses need back-to-back requests
	rspFollowsReq: assert property (
		@(posedge sysClk) disable iff (!arstN)
		(rdRsp.valid && $past(rdRsp.valid)) |-> $past(rdReq.strobe)
	);

endmodule

/* src/spiBlock.sv */
`timescale 1ns/1ps
/*
 * Multi-channel SPI master block. Hosts a register slave, NumChan byte
 * engines and a read/interrupt collector behind one strobe bus.
 */
module spiBlock #(
	parameter int						NumChan		= 4,
	parameter int						BusAdrsBit	= spiBusPkg::BusAdrsBitDef,
	parameter logic [BusAdrsBit-1:0]	BaseAdrs	= 'h0300	// Word address of channel 0
)(
	input	logic					sysClk,
	input	logic					arstN,
	// Host bus
	input	spiBusPkg::busWr_t		wr,
	input	spiBusPkg::busRdReq_t	rdReq,
	output	spiBusPkg::busRdRsp_t	rdRsp,
	output	logic [NumChan-1:0]		irq,
	// SPI pins, one bit per channel
	output	logic [NumChan-1:0]		sck,
	output	logic [NumChan-1:0]		mosi,
	output	logic [NumChan-1:0]		csN,
	input	logic [NumChan-1:0]		miso
);

	import spiCfgPkg::*;

	chanCfg_t [NumChan-1:0]		cfg;	// CSR to engines and collector
	chanStat_t [NumChan-1:0]	stat;	// Engines to collector

	// ------------------------------------------------------------------------
	// Register slave
	// ------------------------------------------------------------------------
	spiCsr #(
		.NumChan		(NumChan),
		.BusAdrsBit		(BusAdrsBit),
		.BaseAdrs		(BaseAdrs)
	) spiCsr_i (
		.sysClk			(sysClk),
		.arstN			(arstN),
		.wr				(wr),
		.cfg			(cfg)
	);

	// ------------------------------------------------------------------------
	// Channel engines
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < NumChan; k++)
	begin : genChan
		spiChannel spiChannel_i (
			.sysClk		(sysClk),
			.arstN		(arstN),
			.cfg		(cfg[k]),
			.miso		(miso[k]),
			.sck		(sck[k]),
			.mosi		(mosi[k]),
			.csN		(csN[k]),
			.stat		(stat[k])
		);
	end

	// Read-back and interrupts
	spiReadCollect #(
		.NumChan		(NumChan),
		.BusAdrsBit		(BusAdrsBit),
		.BaseAdrs		(BaseAdrs)
	) spiReadCollect_i (
		.sysClk			(sysClk),
		.arstN			(arstN),
		.rdReq			(rdReq),
		.cfg			(cfg),
		.stat			(stat),
		.rdRsp			(rdRsp),
		.irq			(irq)
	);

endmodule

/* verif/tbClkGen.sv */
`timescale 1ns/1ps
/*
 * Testbench clock and reset source. 20 ns clock,
 * reset held low for the first two rising edges.
 */
module tbClkGen (
	output	logic	sysClk,
	output	logic	arstN
);

	localparam int HalfPeriod = 10;	// ns

	initial
	begin
		sysClk = 1'b0;
		forever #HalfPeriod sysClk = ~sysClk;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (2) @(posedge sysClk);
		arstN <= 1'b1;	// Release on the second edge
	end

endmodule

/* verif/spiBlockTb.sv */
`timescale 1ns/1ps
/*
 * Trace-driven testbench for the SPI block. Reads operations from
 * verif/spiTrace.txt, drives the host bus and checks read data and irq.
 * Even channels loop mosi back to miso, odd channels see miso high.
 */
module spiBlockTb;

	import spiBusPkg::*;
	import spiCfgPkg::*;

	localparam int			NumChan		= 4;
	localparam busAdrs_t	BaseAdrs	= 16'h0300;
	localparam int			RspWait		= 3;	// Read response limit, cycles

	logic					sysClk;
	logic					arstN;
	busWr_t					wr;
	busRdReq_t				rdReq;
	busRdRsp_t				rdRsp;
	logic [NumChan-1:0]		irq;
	logic [NumChan-1:0]		sck;
	logic [NumChan-1:0]		mosi;
	logic [NumChan-1:0]		csN;
	logic [NumChan-1:0]		miso;

	int						mismatchCnt;
	int						timeoutCnt;
	int						otherCnt;
	logic [NumChan-1:0]		irqAllow;			// Channels allowed to raise irq now
	spiDiv_t				divModel [NumChan];	// Divider as last written
	logic					csModel [NumChan];	// csAssert as last written
	logic [NumChan-1:0]		sckLast;			// sck at the previous falling clock
	int						sckRise [NumChan];	// Rising sck edges seen per channel
	string					curTest;

	tbClkGen tbClkGen_i (
		.sysClk	(sysClk),
		.arstN	(arstN)
	);

	spiBlock spiBlock_i (
		.sysClk	(sysClk),
		.arstN	(arstN),
		.wr		(wr),
		.rdReq	(rdReq),
		.rdRsp	(rdRsp),
		.irq	(irq),
		.sck	(sck),
		.mosi	(mosi),
		.csN	(csN),
		.miso	(miso)
	);

	// ------------------------------------------------------------------------
	// SPI loopback
	// ------------------------------------------------------------------------
	for (genvar k = 0; k < NumChan; k++)
	begin : genLoop
		if (k % 2 == 0)
		begin : genEven
			assign miso[k] = mosi[k];	// Receives its own byte
		end
		else
		begin : genOdd
			assign miso[k] = 1'b1;	// Always 8'hFF
		end
	end

	// Any irq outside the allowed mask is an error, incl. a second pulse
	// Also counts sck rising edges for each channel
	always @(negedge sysClk)
	begin
		if (!arstN)
		begin
			sckLast = '0;
			for (int k = 0; k < NumChan; k++)
			begin
				sckRise[k] = 0;
			end
		end
		else
		begin
			assert ((irq & ~irqAllow) == '0)
			else
			begin
				otherCnt++;
				$display("unexpected irq %b during %s", irq, curTest);
			end
			for (int k = 0; k < NumChan; k++)
			begin
				if (sck[k] && !sckLast[k])
				begin
					sckRise[k]++;
				end
			end
			sckLast = sck;
		end
	end

	// ------------------------------------------------------------------------
	// Bus helpers
	// ------------------------------------------------------------------------
	task automatic compareValue(input string name, input busData_t expVal,
		input busData_t actVal);
		assert (actVal === expVal)
		else
		begin
			mismatchCnt++;
			$display("mismatch %s: expected %h, actual %h", name, expVal, actVal);
		end
	endtask

	// Channel index and register offset of a mapped address
	task automatic splitAdrs(input busAdrs_t adrs, output int chan, output int ofs);
		busAdrs_t rel;
		rel		= adrs - BaseAdrs;
		chan	= int'(rel[15:2]);
		ofs		= int'(rel[1:0]);
	endtask

	// Returns after the edge where the strobe is sampled
	task automatic writeReg(input busAdrs_t adrs, input busData_t data);
		@(posedge sysClk);
		wr <= '{adrs: adrs, data: data, strobe: 1'b1};
		@(posedge sysClk);
		wr.strobe <= 1'b0;
	endtask

	task automatic readCheck(input string name, input busAdrs_t adrs,
		input busData_t expVal);
		int waitCnt;
		@(posedge sysClk);
		rdReq <= '{adrs: adrs, strobe: 1'b1};
		@(posedge sysClk);
		rdReq.strobe <= 1'b0;
		@(negedge sysClk);	// First chance for valid
		waitCnt = 0;
		while (!rdRsp.valid && waitCnt < RspWait)
		begin
			@(negedge sysClk);
			waitCnt++;
		end
		assert (rdRsp.valid)
		else
		begin
			timeoutCnt++;
			$display("no read response for %s within %0d cycles", name, RspWait);
		end
		if (rdRsp.valid)
		begin
			compareValue(name, expVal, rdRsp.data);
			assert (waitCnt == 0)
			else
			begin
				otherCnt++;
				$display("read response for %s came %0d cycles late", name, waitCnt);
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Trace operations
	// ------------------------------------------------------------------------
	task automatic writeOp(input string name, input busAdrs_t adrs, input busData_t val);
		int chan;
		int ofs;
		writeReg(adrs, val);
		if (adrs >= BaseAdrs && adrs < BaseAdrs + 16'(NumChan * 4))
		begin
			splitAdrs(adrs, chan, ofs);
			if (ofs == int'(RegDiv))
			begin
				divModel[chan] = val[15:0];
			end
			else if (ofs == int'(RegCtrl))
			begin
				csModel[chan] = val[1];
				@(posedge sysClk);	// csN follows one edge later
				@(negedge sysClk);
				compareValue({name, "CsN"}, 32'(!val[1]), 32'(csN[chan]));
			end
		end
	endtask

	// Byte in val[7:0]; val[16] adds a second RegTx write of val[15:8] while busy
	task automatic runTransfer(input string name, input busAdrs_t adrs, input busData_t val);
		int			chan;
		int			ofs;
		int			limit;
		int			waitCnt;
		int			riseBase;
		busAdrs_t	ctrlAdrs;
		splitAdrs(adrs, chan, ofs);
		limit		= 20 * (int'(divModel[chan]) + 1) + 10;
		ctrlAdrs	= adrs - 16'd2;
		@(posedge sysClk);
		irqAllow[chan] = 1'b1;
		riseBase = sckRise[chan];	// Channel idle, sck low
		writeReg(adrs, {24'h0, val[7:0]});
		readCheck({name, "Busy"}, ctrlAdrs, 32'h4 | {30'h0, csModel[chan], 1'b1});
		assert (csN[chan] == 1'b0)
		else
		begin
			otherCnt++;
			$display("csN high on channel %0d while busy in %s", chan, name);
		end
		if (val[16])
		begin
			writeReg(adrs, {24'h0, val[15:8]});	// Dropped by busy channel
		end
		waitCnt = 0;
		while (!irq[chan] && waitCnt < limit)
		begin
			@(negedge sysClk);
			waitCnt++;
		end
		assert (irq[chan])
		else
		begin
			timeoutCnt++;
			$display("no irq on channel %0d for %s within %0d cycles", chan, name, limit);
		end
		@(posedge sysClk);
		irqAllow[chan] = 1'b0;	// Pulse must be over now
		if (val[16])
		begin
			// Room for a wrongly started second byte to finish
			waitCnt = 0;
			while (waitCnt < limit)
			begin
				@(negedge sysClk);
				waitCnt++;
			end
		end
		// One byte is eight sck pulses, pins back low afterwards
		compareValue({name, "SckRise"}, 32'd8, 32'(sckRise[chan] - riseBase));
		compareValue({name, "PinsIdle"}, 32'h0, {30'h0, sck[chan], mosi[chan]});
	endtask

	// Disabled channel, irq monitor flags any done
	task automatic expectNoDone(input busAdrs_t adrs, input busData_t val);
		int chan;
		int ofs;
		int waitCnt;
		splitAdrs(adrs, chan, ofs);
		writeReg(adrs, val);
		waitCnt = 0;
		while (waitCnt < 20 * (int'(divModel[chan]) + 1) + 10)
		begin
			@(negedge sysClk);
			waitCnt++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------
	initial
	begin
		int			fd;
		int			code;
		int			waitCnt;
		string		op;
		string		name;
		string		line;
		busAdrs_t	adrs;
		busData_t	val;

		wr			<= '0;
		rdReq		<= '0;
		irqAllow	= '0;
		mismatchCnt	= 0;
		timeoutCnt	= 0;
		otherCnt	= 0;
		curTest		= "reset";
		for (int k = 0; k < NumChan; k++)
		begin
			divModel[k]	= '0;
			csModel[k]	= 1'b0;
		end

		waitCnt = 0;
		while (arstN !== 1'b1 && waitCnt < 10)
		begin
			@(posedge sysClk);
			waitCnt++;
		end
		assert (arstN === 1'b1)
		else
		begin
			timeoutCnt++;
			$display("reset never released");
		end

		fd = $fopen("verif/spiTrace.txt", "r");
		if (fd == 0)
		begin
			otherCnt++;
			$display("cannot open trace file verif/spiTrace.txt");
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fscanf(fd, "%s", op);
				if (code != 1)
				begin
					break;	// End of file
				end
				if (op.getc(0) == "#")
				begin
					code = $fgets(line, fd);	// Comment line
				end
				else
				begin
					code = $fscanf(fd, "%s %h %h", name, adrs, val);
					curTest = name;
					if (code != 3)
					begin
						otherCnt++;
						$display("malformed trace line after operation %s", op);
					end
					else
					begin
						case (op)
							"W":		writeOp(name, adrs, val);
							"R":		readCheck(name, adrs, val);
							"T":		runTransfer(name, adrs, val);
							"N":		expectNoDone(adrs, val);
							default:
							begin
								otherCnt++;
								$display("unknown trace operation %s", op);
							end
						endcase
					end
				end
			end
			$fclose(fd);
		end

		$display("errors: %0d mismatch, %0d timeout, %0d other",
			mismatchCnt, timeoutCnt, otherCnt);
		if (mismatchCnt + timeoutCnt + otherCnt == 0)
		begin
			$display("all tests passed");
		end
		else
		begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

/* spiSub.f */
src/spiBusPkg.sv
src/spiCfgPkg.sv
src/spiCsr.sv
src/spiChannel.sv
src/spiReadCollect.sv
src/spiBlock.sv
verif/tbClkGen.sv
verif/spiBlockTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the SPI block testbench with Verilator.
# Exit status is 0 only when the simulation log holds the pass line.

cd "$(dirname "$0")" || exit 1

TOP=spiBlockTb
LOG=sim.log
EXE=spiSubSim

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$TOP" -f spiSub.f -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

/* verif/spiTrace.txt */
# op name adrs value, hex; W write, R read and compare, T RegTx write and wait for irq
# N RegTx write with no irq expected; T value bit 16 adds a busy write of bits 15:8
R rstCtrl0 300 0
R rstDiv0 301 0
R rstRx0 303 0
R rstCtrl1 304 0
R rstDiv1 305 0
R rstRx1 307 0
R rstCtrl2 308 0
R rstDiv2 309 0
R rstRx2 30b 0
R rstCtrl3 30c 0
R rstDiv3 30d 0
R rstRx3 30f 0
W ctrl0 300 3
R ctrlBack0 300 3
W div0 301 1234
R divBack0 301 1234
R unmapLow 2ff 0
R unmapHigh 310 0
W div0Run 301 0
W ctrl0Run 300 1
T xfer0a 302 a5
R rx0a 303 a5
T xfer0b 302 3c
R rx0b 303 3c
W ctrl2 308 1
W div2 309 3
T xfer2a 30a 96
R rx2a 30b 96
T xfer2b 30a 01
R rx2b 30b 01
W ctrl1 304 1
W div1 305 1
T xfer1 306 5a
R rx1 307 ff
W ctrl3 30c 1
T xfer3 30e 00
R rx3 30f ff
T drop0 302 1c381
R dropRx0 303 81
R dropTx0 302 c3
W dis2 308 2
N noXfer2 30a 77
R disBusy2 308 2
W csOff2 308 0
